/* Makefile */
# Verilator build and run of the MMU read side testbench

VERILATOR ?= verilator
TOP       ?= tb_mmu_top
SEED_LOG  ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP SEED_LOG OBJ_DIR FILELIST VFLAGS"

$(SIM_BIN): $(SOURCES) tb_mmu_model.svh $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(SEED_LOG); then echo "test failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(SEED_LOG) || { echo "no pass line in log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

/* axi_pkg.sv */
// AXI4 read-channel definitions for the MMU read master
// constant AR fields and packed AR and R channel payloads
package axi_pkg;

    localparam int ADDR_W   = 64;
    localparam int DATA_W   = 64;
    localparam int AXI_ID_W = 8;

    // fixed AR attributes, tied off at the top
    localparam logic [AXI_ID_W-1:0] AR_ID        = '0;
    localparam logic [1:0]          BURST_INCR   = 2'b01;  // incrementing burst
    localparam logic [2:0]          SIZE_8B      = 3'b011; // 8 bytes per beat
    localparam logic                LOCK_NORMAL  = 1'b0;
    localparam logic [3:0]          CACHE_DEVICE = 4'b0000; // non-bufferable
    localparam logic [2:0]          PROT_DATA    = 3'b000;  // unprivileged data
    localparam logic [3:0]          QOS_NONE     = 4'b0000;

    // read address payload
    typedef struct packed {
        logic [ADDR_W-1:0] addr; // byte address of first beat
        logic [7:0]        len;  // beats minus one
    } ar_t;

    // read data payload
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last; // final beat of burst
        logic [1:0]        resp;
    } r_t;

endpackage

/* axi_read_engine.sv */
// AXI read engine: serves line refills and walker PTE reads one at a time,
// refill first, and collects the R beats into a line buffer
`timescale 1ns/1ps

module axi_read_engine #(
    parameter int line_beats = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  ptw_pkg::line_rqst_t           line_held,
    input  logic                          pte_rd_strobe,
    input  logic [ptw_pkg::ID_W-1:0]      pte_rd_id,
    input  logic [axi_pkg::ADDR_W-1:0]    pte_rd_addr,
    output ptw_pkg::line_resp_t           line_resp,
    output logic                          pte_rd_done,
    output logic [axi_pkg::DATA_W-1:0]    pte_rd_data,
    output axi_pkg::ar_t                  ar,
    output logic                          ar_valid,
    input  logic                          ar_ready,
    input  axi_pkg::r_t                   r,
    input  logic                          r_valid,
    output logic                          r_ready
);
    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_RESP} state_t;

    state_t                                 state;
    logic [ptw_pkg::ID_W-1:0]               pend_id;   // walker read waiting
    logic [axi_pkg::ADDR_W-1:0]             pend_addr;
    logic [ptw_pkg::ID_W-1:0]               cur_id;    // transaction in flight
    logic                                   is_line;
    logic [line_beats-1:0][axi_pkg::DATA_W-1:0] line_buf;
    logic                                   beat;
    logic                                   bc_done;
    logic [2:0]                             index;

    assign beat = r_valid && r_ready;

    beat_counter #(.line_beats(line_beats)) beat_counter_i (
        .clk       (clk),
        .rst       (rst),
        .start     (ar_valid && ar_ready),
        .beat      (beat),
        .burst_len (ar.len),
        .index     (index),
        .done      (bc_done)
    );

    // the walker strobes once, so keep its read until it is picked
    always_ff @(posedge clk) begin
        if (rst) pend_id <= '0;
        else if (pte_rd_strobe) pend_id <= pte_rd_id;
        else if (state == S_IDLE && !(|line_held.id)) pend_id <= '0;
    end

    always_ff @(posedge clk) begin
        if (pte_rd_strobe) pend_addr <= pte_rd_addr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (|line_held.id) begin // refill wins
                        cur_id   <= line_held.id;
                        is_line  <= 1'b1;
                        ar.addr  <= line_held.addr;
                        ar.len   <= 8'(line_beats - 1);
                        ar_valid <= 1'b1;
                        state    <= S_ADDR;
                    end else if (|pend_id) begin
                        cur_id   <= pend_id;
                        is_line  <= 1'b0;
                        ar.addr  <= pend_addr;
                        ar.len   <= 8'd0; // single beat
                        ar_valid <= 1'b1;
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (beat) begin
                        line_buf[index] <= r.data;
                        if (bc_done) begin
                            r_ready <= 1'b0;
                            state   <= S_RESP;
                        end
                    end
                end
                S_RESP: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign line_resp.id   = (state == S_RESP && is_line) ? cur_id : '0;
    assign line_resp.data = line_buf;
    assign pte_rd_done    = (state == S_RESP) && !is_line;
    assign pte_rd_data    = line_buf[0]; // PTE reads land in slot 0

    // the walker asks again only after its previous read was picked
    pte_rd_single: assert property (@(posedge clk) disable iff (rst)
        pte_rd_strobe |-> !(|pend_id));

    // slave's last flag must agree with our own beat count
    last_on_count: assert property (@(posedge clk) disable iff (rst)
        beat |-> (r.last == bc_done));

endmodule

/* beat_counter.sv */
// Beat counter for AXI read bursts: tracks the buffer slot of each
// accepted beat and flags the beat that completes the burst
`timescale 1ns/1ps

module beat_counter #(
    parameter int line_beats = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,     // AR handshake, new burst
    input  logic       beat,      // accepted R beat
    input  logic [7:0] burst_len, // AR length, beats minus one
    output logic [2:0] index,
    output logic       done
);
    localparam logic [2:0] last_idx = 3'(line_beats - 1);

    always_ff @(posedge clk) begin
        if (rst || start) begin
            index <= '0;
        end else if (beat && index != last_idx) begin
            index <= index + 3'd1; // holds at the top slot
        end
    end

    // final beat once the count reaches the burst length
    assign done = beat && ({5'd0, index} == burst_len);

endmodule

/* mmu_top.sv */
// MMU read side top: request holders, page table walker and AXI read
// engine, with the constant AR attributes tied off here
`timescale 1ns/1ps

module mmu_top #(
    parameter int line_beats = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  ptw_pkg::walk_rqst_t walk_rqst,
    output ptw_pkg::walk_resp_t walk_resp,
    input  ptw_pkg::line_rqst_t line_rqst,
    output ptw_pkg::line_resp_t line_resp,
    output axi_pkg::ar_t        ar,
    output logic                ar_valid,
    input  logic                ar_ready,
    output logic [axi_pkg::AXI_ID_W-1:0] arid,
    output logic [1:0]          arburst,
    output logic [2:0]          arsize,
    output logic                arlock,
    output logic [3:0]          arcache,
    output logic [2:0]          arprot,
    output logic [3:0]          arqos,
    input  axi_pkg::r_t         r,
    input  logic                r_valid,
    output logic                r_ready
);
    ptw_pkg::walk_rqst_t      walk_held;
    ptw_pkg::line_rqst_t      line_held;
    logic                     pte_rd_strobe;
    logic [ptw_pkg::ID_W-1:0] pte_rd_id;
    logic [63:0]              pte_rd_addr;
    logic                     pte_rd_done;
    logic [63:0]              pte_rd_data;

    req_hold #(.payload_t(ptw_pkg::walk_rqst_t)) walk_hold (
        .clk     (clk),
        .rst     (rst),
        .rqst    (walk_rqst),
        .rqst_id (walk_rqst.id),
        .resp_id (walk_resp.id),
        .held    (walk_held),
        .held_id ()
    );

    req_hold #(.payload_t(ptw_pkg::line_rqst_t)) line_hold (
        .clk     (clk),
        .rst     (rst),
        .rqst    (line_rqst),
        .rqst_id (line_rqst.id),
        .resp_id (line_resp.id), // refill answer releases the holder
        .held    (line_held),
        .held_id ()
    );

    ptw_fsm ptw_fsm_i (
        .clk           (clk),
        .rst           (rst),
        .walk_held     (walk_held),
        .pte_rd_strobe (pte_rd_strobe),
        .pte_rd_id     (pte_rd_id),
        .pte_rd_addr   (pte_rd_addr),
        .pte_rd_done   (pte_rd_done),
        .pte_rd_data   (pte_rd_data),
        .walk_resp     (walk_resp)
    );

    axi_read_engine #(.line_beats(line_beats)) axi_read_engine_i (
        .clk           (clk),
        .rst           (rst),
        .line_held     (line_held),
        .pte_rd_strobe (pte_rd_strobe),
        .pte_rd_id     (pte_rd_id),
        .pte_rd_addr   (pte_rd_addr),
        .line_resp     (line_resp),
        .pte_rd_done   (pte_rd_done),
        .pte_rd_data   (pte_rd_data),
        .ar            (ar),
        .ar_valid      (ar_valid),
        .ar_ready      (ar_ready),
        .r             (r),
        .r_valid       (r_valid),
        .r_ready       (r_ready)
    );

    assign arid    = axi_pkg::AR_ID;
    assign arburst = axi_pkg::BURST_INCR;
    assign arsize  = axi_pkg::SIZE_8B;
    assign arlock  = axi_pkg::LOCK_NORMAL;
    assign arcache = axi_pkg::CACHE_DEVICE;
    assign arprot  = axi_pkg::PROT_DATA;
    assign arqos   = axi_pkg::QOS_NONE;

endmodule

/* ptw_fsm.sv */
// Page table walker for Sv39, Sv48 and Sv57: fetches one PTE per level,
// applies the leaf checks and returns the physical page or a fault
`timescale 1ns/1ps

module ptw_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  ptw_pkg::walk_rqst_t      walk_held,
    output logic                     pte_rd_strobe,
    output logic [ptw_pkg::ID_W-1:0] pte_rd_id,
    output logic [63:0]              pte_rd_addr,
    input  logic                     pte_rd_done,
    input  logic [63:0]              pte_rd_data,
    output ptw_pkg::walk_resp_t      walk_resp
);
    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_WAIT, S_CHECK, S_DONE} state_t;

    state_t                          state;
    logic [ptw_pkg::ID_W-1:0]        req_id;
    logic [4:0][ptw_pkg::VPN_W-1:0]  vpn;   // vadd[56:12] split by level
    logic [ptw_pkg::PPN_W-1:0]       ppn;   // table base, then result page
    logic [3:0]                      acc;
    logic [2:0]                      lvl;
    logic [63:0]                     pte;
    logic                            fault;
    logic [7:0]                      perm;
    logic                            is_leaf;
    logic                            misaligned;
    logic                            leaf_fault;
    logic [ptw_pkg::PPN_W-1:0]       leaf_ppn;

    // superpage handling, fields below the leaf level
    always_comb begin
        leaf_ppn   = pte[10 +: ptw_pkg::PPN_W];
        misaligned = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (i < lvl) begin
                if (|pte[10 + 9 * i +: 9]) misaligned = 1'b1;
                leaf_ppn[9 * i +: 9] = vpn[i]; // page offset bits from the VA
            end
        end
    end

    assign is_leaf    = pte[ptw_pkg::PTE_R] | pte[ptw_pkg::PTE_X];
    assign leaf_fault = ~pte[ptw_pkg::PTE_A]
                      | (acc[ptw_pkg::PTE_W] & ~pte[ptw_pkg::PTE_D])
                      | |(acc[ptw_pkg::PTE_X:ptw_pkg::PTE_R]
                          & ~pte[ptw_pkg::PTE_X:ptw_pkg::PTE_R])
                      | misaligned;

    assign pte_rd_strobe = (state == S_ADDR);
    assign pte_rd_id     = req_id;
    assign pte_rd_addr   = {8'd0, ppn, vpn[lvl], 3'd0};

    assign walk_resp.id    = (state == S_DONE) ? req_id : '0;
    assign walk_resp.fault = fault;
    assign walk_resp.perm  = fault ? 8'd0 : perm;
    assign walk_resp.padd  = fault ? 64'd0 : {8'd0, ppn, 12'd0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            fault <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (|walk_held.id) begin
                        req_id <= walk_held.id;
                        vpn    <= walk_held.vadd[56:12];
                        ppn    <= walk_held.satp[43:0];
                        acc    <= walk_held.acc;
                        fault  <= 1'b0;
                        perm   <= 8'd0;
                        state  <= S_ADDR;
                        case (walk_held.satp[63:60])
                            ptw_pkg::MODE_SV39: lvl <= 3'd2;
                            ptw_pkg::MODE_SV48: lvl <= 3'd3;
                            ptw_pkg::MODE_SV57: lvl <= 3'd4;
                            default: begin // unsupported mode
                                fault <= 1'b1;
                                state <= S_DONE;
                            end
                        endcase
                    end
                end
                S_ADDR: state <= S_WAIT; // read strobed this cycle
                S_WAIT: begin
                    if (pte_rd_done) begin
                        pte   <= pte_rd_data;
                        state <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (!pte[ptw_pkg::PTE_V]) begin
                        fault <= 1'b1;
                        state <= S_DONE;
                    end else if (is_leaf) begin
                        state <= S_DONE;
                        if (leaf_fault) begin
                            fault <= 1'b1;
                        end else begin
                            ppn  <= leaf_ppn;
                            perm <= pte[7:0];
                        end
                    end else if (lvl == 3'd0) begin // pointer at the last level
                        fault <= 1'b1;
                        state <= S_DONE;
                    end else begin
                        ppn   <= pte[10 +: ptw_pkg::PPN_W];
                        lvl   <= lvl - 3'd1;
                        state <= S_ADDR;
                    end
                end
                S_DONE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

/* ptw_pkg.sv */
// Page table walker definitions: paging modes, PTE flag positions and
// the request and response payloads of the walk and line refill ports
package ptw_pkg;

    localparam int ID_W   = 8;   // request ID, zero means no request
    localparam int VPN_W  = 9;   // one virtual page number field
    localparam int PPN_W  = 44;  // physical page number
    localparam int LINE_W = 512; // one cache line

    // SATP mode field codes
    localparam logic [3:0] MODE_SV39 = 4'd8;  // 3 levels
    localparam logic [3:0] MODE_SV48 = 4'd9;  // 4 levels
    localparam logic [3:0] MODE_SV57 = 4'd10; // 5 levels

    // PTE flag bit positions
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_A = 6;
    localparam int PTE_D = 7;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [63:0]     vadd; // virtual address
        logic [63:0]     satp;
        logic [3:0]      acc;  // requested access, same bit order as PTE flags
    } walk_rqst_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic            fault;
        logic [7:0]      perm; // low PTE bits of the leaf
        logic [63:0]     padd; // physical page address
    } walk_resp_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [63:0]     addr; // line address
    } line_rqst_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [LINE_W-1:0] data; // beat i at bits 64*i and up
    } line_resp_t;

endpackage

/* req_hold.sv */
// Request holder: captures a strobed request and keeps it until a
// response with the same ID comes back, for any payload type
`timescale 1ns/1ps

module req_hold #(
    parameter type payload_t = logic
) (
    input  logic                     clk,
    input  logic                     rst,
    input  payload_t                 rqst,
    input  logic [ptw_pkg::ID_W-1:0] rqst_id,
    input  logic [ptw_pkg::ID_W-1:0] resp_id,
    output payload_t                 held,
    output logic [ptw_pkg::ID_W-1:0] held_id
);
    logic                     ready;   // buffer empty or being answered
    logic [ptw_pkg::ID_W-1:0] id_next;
    payload_t                 payload_next;

    assign ready        = ~|held_id | (held_id == resp_id);
    assign id_next      = ready ? rqst_id : held_id;
    assign payload_next = ready ? rqst : held;

    always_ff @(posedge clk) begin
        if (rst) held_id <= '0;
        else held_id <= id_next;
    end

    always_ff @(posedge clk) held <= payload_next; // payload register

    // a response only ever answers the pending request
    resp_matches_held: assert property (@(posedge clk) disable iff (rst)
        |resp_id |-> resp_id == held_id);

endmodule

/* tb_mmu_model.svh */
// Testbench model of the MMU read side: sparse memory behind the AXI slave,
// page table builder, LCG and a reference page walk
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

logic [63:0] mem [logic [63:0]];         // keyed by 8-byte aligned address
logic [31:0] lcg_state  = 32'hfa1185a5;
logic [43:0] next_table = 44'h100;       // fresh table page for every level

function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]}; // weak low bits moved up
endfunction

function automatic logic [63:0] mem_word(input logic [63:0] addr);
    logic [63:0] a;
    a = {addr[63:3], 3'd0};
    if (mem.exists(a)) return mem[a];
    return a ^ {a[31:0], a[63:32]} ^ 64'h9e37_79b9_7f4a_7c15; // unwritten words
endfunction

function automatic logic [63:0] pte_addr(input logic [43:0] ppn, input logic [63:0] va,
                                         input int lvl);
    return {8'd0, ppn, va[12 + 9 * lvl +: 9], 3'd0};
endfunction

// pointer chain from the root down to a leaf at leaf_lvl
task automatic build_walk(input logic [3:0] mode, input int leaf_lvl, input logic [7:0] flags,
                          input logic misalign, output ptw_pkg::walk_rqst_t rq);
    logic [43:0] table_ppn;
    logic [43:0] leaf_ppn;
    int          top;
    top     = int'(mode) - 6;
    rq      = '0;
    rq.vadd = {rand32(), rand32()};
    table_ppn = next_table;
    next_table = next_table + 44'd1;
    rq.satp = {mode, 16'd0, table_ppn};
    for (int lvl = top; lvl > leaf_lvl; lvl--) begin
        mem[pte_addr(table_ppn, rq.vadd, lvl)] = {10'd0, next_table, 10'h001};
        table_ppn  = next_table;
        next_table = next_table + 44'd1;
    end
    leaf_ppn = 44'({rand32(), rand32()});
    leaf_ppn = leaf_ppn & ~((44'd1 << (9 * leaf_lvl)) - 44'd1); // superpage alignment
    if (misalign) leaf_ppn[0] = 1'b1;
    mem[pte_addr(table_ppn, rq.vadd, leaf_lvl)] = {10'd0, leaf_ppn, 2'b00, flags};
endtask

function automatic ptw_pkg::line_rqst_t make_line(input logic [7:0] id);
    ptw_pkg::line_rqst_t rq;
    logic [63:0]         a;
    a       = {rand32(), rand32()};
    rq.id   = id;
    rq.addr = {1'b1, a[62:6], 6'd0}; // well above the page tables
    for (int i = 0; i < 8; i++) begin
        if (!a[i]) mem[rq.addr + 64'(8 * i)] = {rand32(), rand32()};
    end
    return rq;
endfunction

function automatic ptw_pkg::walk_resp_t ref_walk(input ptw_pkg::walk_rqst_t rq);
    ptw_pkg::walk_resp_t res;
    logic [43:0]         ppn;
    logic [63:0]         pte;
    logic                bad;
    int                  lvl;
    res       = '0;
    res.id    = rq.id;
    res.fault = 1'b1; // cleared only by a good leaf
    case (rq.satp[63:60])
        ptw_pkg::MODE_SV39: lvl = 2;
        ptw_pkg::MODE_SV48: lvl = 3;
        ptw_pkg::MODE_SV57: lvl = 4;
        default: return res;
    endcase
    ppn = rq.satp[43:0];
    while (lvl >= 0) begin
        pte = mem_word(pte_addr(ppn, rq.vadd, lvl));
        if (!pte[ptw_pkg::PTE_V]) return res;
        if (pte[ptw_pkg::PTE_R] || pte[ptw_pkg::PTE_X]) begin
            bad = !pte[ptw_pkg::PTE_A]
                || (rq.acc[ptw_pkg::PTE_W] && !pte[ptw_pkg::PTE_D])
                || ((rq.acc[3:1] & ~pte[3:1]) != 3'd0);
            ppn = pte[53:10];
            for (int i = 0; i < lvl; i++) begin
                if (ppn[9 * i +: 9] != 9'd0) bad = 1'b1;
                ppn[9 * i +: 9] = rq.vadd[12 + 9 * i +: 9];
            end
            if (bad) return res;
            res.fault = 1'b0;
            res.perm  = pte[7:0];
            res.padd  = {8'd0, ppn, 12'd0};
            return res;
        end
        ppn = pte[53:10];
        lvl--;
    end
    return res; // pointer found at level 0
endfunction

`endif

/* tb_mmu_top.sv */
// Testbench for the MMU read side: random page walks and line refills
// checked against a reference model, with an AXI read slave that stalls
`timescale 1ns/1ps

module tb_mmu_top;
    logic                clk = 1'b0;
    logic                rst;
    ptw_pkg::walk_rqst_t walk_rqst;
    ptw_pkg::walk_resp_t walk_resp;
    ptw_pkg::line_rqst_t line_rqst;
    ptw_pkg::line_resp_t line_resp;
    axi_pkg::ar_t        ar;
    logic                ar_valid;
    logic                ar_ready;
    logic [7:0]          arid;
    logic [1:0]          arburst;
    logic [2:0]          arsize;
    logic                arlock;
    logic [3:0]          arcache;
    logic [2:0]          arprot;
    logic [3:0]          arqos;
    axi_pkg::r_t         r;
    logic                r_valid;
    logic                r_ready;
    logic [63:0]         burst_addr = '0;
    int                  burst_left = 0;
    int                  issued = 0;

    `include "tb_mmu_model.svh"

    always #50 clk = ~clk;

    mmu_top #(.line_beats(8)) mmu_top_i (
        .clk       (clk),
        .rst       (rst),
        .walk_rqst (walk_rqst),
        .walk_resp (walk_resp),
        .line_rqst (line_rqst),
        .line_resp (line_resp),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .arid      (arid),
        .arburst   (arburst),
        .arsize    (arsize),
        .arlock    (arlock),
        .arcache   (arcache),
        .arprot    (arprot),
        .arqos     (arqos),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready)
    );

    // slave burst tracking, sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            burst_left <= 0;
        end else if (ar_valid && ar_ready) begin
            check_value("arid", 64'd0, 64'(arid));
            check_value("arburst incr", 64'(2'b01), 64'(arburst));
            check_value("arsize 8 bytes", 64'(3'b011), 64'(arsize));
            check_value("arlock", 64'd0, 64'(arlock));
            check_value("arcache", 64'd0, 64'(arcache));
            check_value("arprot", 64'd0, 64'(arprot));
            check_value("arqos", 64'd0, 64'(arqos));
            burst_addr <= ar.addr;
            burst_left <= int'(ar.len) + 1;
        end else if (r_valid && r_ready) begin
            burst_addr <= burst_addr + 64'd8;
            burst_left <= burst_left - 1;
        end
    end

    // slave outputs, random stalls on both channels
    always @(negedge clk) begin
        ar_ready = (rand32() % 4) != 0;
        r_valid  = (burst_left > 0) && ((rand32() % 4) != 0);
        r.data   = mem_word(burst_addr);
        r.last   = burst_left == 1;
        r.resp   = 2'b00;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // strobe the requests with a non-zero ID and wait for each response
    task automatic run_requests(input ptw_pkg::walk_rqst_t wq, input ptw_pkg::line_rqst_t lq,
                                output ptw_pkg::walk_resp_t wr, output ptw_pkg::line_resp_t lr);
        logic walk_wait;
        logic line_wait;
        walk_wait = |wq.id;
        line_wait = |lq.id;
        wr = '0;
        lr = '0;
        @(negedge clk);
        walk_rqst = wq;
        line_rqst = lq;
        issued = issued + int'(walk_wait) + int'(line_wait);
        @(negedge clk);
        walk_rqst = '0;
        line_rqst = '0;
        while (walk_wait || line_wait) begin
            if (walk_wait && walk_resp.id != '0) begin
                wr = walk_resp;
                walk_wait = 1'b0;
            end
            if (line_wait && line_resp.id != '0) begin
                lr = line_resp;
                line_wait = 1'b0;
            end
            if (walk_wait || line_wait) @(negedge clk);
        end
    endtask

    task automatic run_and_check(input string name, input ptw_pkg::walk_rqst_t wq,
                                 input ptw_pkg::line_rqst_t lq, input logic fault_expected);
        ptw_pkg::walk_resp_t exp;
        ptw_pkg::walk_resp_t wr;
        ptw_pkg::line_resp_t lr;
        exp = ref_walk(wq);
        run_requests(wq, lq, wr, lr);
        if (|wq.id) begin
            check_value({name, " walk id"}, 64'(wq.id), 64'(wr.id));
            check_value({name, " fault"}, 64'(fault_expected), 64'(wr.fault));
            check_value({name, " model fault"}, 64'(exp.fault), 64'(wr.fault));
            check_value({name, " perm"}, 64'(exp.perm), 64'(wr.perm));
            check_value({name, " padd"}, exp.padd, wr.padd);
        end
        if (|lq.id) begin
            check_value({name, " line id"}, 64'(lq.id), 64'(lr.id));
            for (int i = 0; i < 8; i++) begin
                check_value($sformatf("%s beat %0d", name, i),
                            mem_word(lq.addr + 64'(8 * i)), lr.data[64 * i +: 64]);
            end
        end
    endtask

    task automatic run_fault(input string name, input logic [3:0] mode,
                             input logic [7:0] flags, input logic [3:0] acc,
                             input logic [7:0] id);
        ptw_pkg::walk_rqst_t wq;
        ptw_pkg::line_rqst_t no_line;
        no_line = '0;
        build_walk(ptw_pkg::MODE_SV48, 0, flags, 1'b0, wq);
        wq.satp[63:60] = mode; // may be an unsupported code
        wq.id  = id;
        wq.acc = acc;
        run_and_check(name, wq, no_line, 1'b1);
    endtask

    initial begin
        ptw_pkg::walk_rqst_t wq;
        ptw_pkg::walk_rqst_t no_walk;
        ptw_pkg::line_rqst_t no_line;
        logic [31:0]         rnd;
        logic [3:0]          mode;
        logic [7:0]          flags;
        int                  leaf;

        rst       = 1'b1;
        walk_rqst = '0;
        line_rqst = '0;
        ar_ready  = 1'b0;
        r_valid   = 1'b0;
        r         = '0;
        no_walk   = '0;
        no_line   = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        check_value("reset ar_valid", 64'd0, 64'(ar_valid));
        check_value("reset r_ready", 64'd0, 64'(r_ready));
        check_value("reset walk id", 64'd0, 64'(walk_resp.id));
        check_value("reset line id", 64'd0, 64'(line_resp.id));

        for (int n = 0; n < 4; n++) begin
            run_and_check("refill", no_walk, make_line(8'(n + 1)), 1'b0);
        end

        // 4 KiB pages, every mode
        for (int n = 0; n < 12; n++) begin
            rnd   = rand32();
            mode  = ptw_pkg::MODE_SV39 + 4'(n % 3);
            flags = 8'hC3 | {2'b00, rnd[5:2], 2'b00};
            build_walk(mode, 0, flags, 1'b0, wq);
            wq.id  = 8'(8'h10 + n);
            wq.acc = {flags[3:1] & rnd[10:8], 1'b0};
            run_and_check("walk 4k", wq, no_line, 1'b0);
        end

        // superpages at levels 1 and 2
        for (int n = 0; n < 6; n++) begin
            rnd  = rand32();
            mode = ptw_pkg::MODE_SV39 + 4'(n % 3);
            build_walk(mode, 1 + n / 3, 8'hCF, 1'b0, wq);
            wq.id  = 8'(8'h20 + n);
            wq.acc = {rnd[2:0], 1'b0};
            run_and_check("superpage", wq, no_line, 1'b0);
        end
        build_walk(ptw_pkg::MODE_SV48, 2, 8'hCF, 1'b1, wq);
        wq.id = 8'h2f;
        run_and_check("misaligned superpage", wq, no_line, 1'b1);

        run_fault("bad satp mode", 4'd5, 8'hCF, 4'b0010, 8'h30);
        run_fault("pte invalid", ptw_pkg::MODE_SV48, 8'hCE, 4'b0010, 8'h31);
        run_fault("accessed clear", ptw_pkg::MODE_SV48, 8'h8F, 4'b0010, 8'h32);
        run_fault("write clean page", ptw_pkg::MODE_SV48, 8'h4F, 4'b0100, 8'h33);
        run_fault("perm outside pte", ptw_pkg::MODE_SV48, 8'hC3, 4'b1000, 8'h34);

        // walk and refill strobed in the same cycle
        for (int n = 0; n < 16; n++) begin
            rnd   = rand32();
            mode  = ptw_pkg::MODE_SV39 + 4'(rnd[17:16] % 2'd3);
            leaf  = int'(rnd[15:8]) % (int'(mode) - 5);
            flags = 8'hC3 | {2'b00, rnd[5:2], 2'b00};
            build_walk(mode, leaf, flags, 1'b0, wq);
            wq.id  = 8'(8'h40 + n);
            wq.acc = {flags[3:1] & rnd[22:20], 1'b0};
            run_and_check("concurrent", wq, make_line(8'(8'h80 + n)), 1'b0);
        end

        $display("*** PASSED ***");
        $finish;
    end

    // limit grows with every issued request
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 2000 * (issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no response after %0d cycles with %0d requests issued",
                 cycles, issued);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* vlog.f */
+incdir+.
axi_pkg.sv
ptw_pkg.sv
req_hold.sv
beat_counter.sv
axi_read_engine.sv
ptw_fsm.sv
mmu_top.sv
tb_mmu_top.sv
